//--- hazardUnit_defs.svh
`ifndef HAZ_DEFS_SVH
`define HAZ_DEFS_SVH

// Datapath and address width
`define DATA_W 16

// Eight architectural registers
`define REG_AW 3

// Opcodes, taken from instr[15:11]
`define OP_NOP 5'b00001
`define OP_JR  5'b00111
`define OP_ST  5'b10000
`define OP_LD  5'b10001

// Class prefixes, taken from instr[15:13]
`define CLS_JUMP   3'b001
`define CLS_BRANCH 3'b011

// Stages tracked after issue: ID, EX, MEM, WB
`define TRACK_DEPTH 4

`endif

//--- hazardPkg.sv
`default_nettype none

`include "hazardUnit_defs.svh"

package hazardPkg;

    // Everything fetch and decode hand over for one instruction
    typedef struct packed {
        logic [`DATA_W-1:0] instr;
        logic [`REG_AW-1:0] rd;
        logic               rdWrite;
        logic               memEnable;
        logic [`DATA_W-1:0] baseData;
        logic [`DATA_W-1:0] imm;
    } issueReq_t;

    // Decoded view of the presented instruction
    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic               isNop;
        logic               isJr;
        logic               isJump;
        logic               isLoad;
        logic               memEnable;
        logic [`DATA_W-1:0] memAddr;
        logic [`REG_AW-1:0] rd;
        logic               rdWrite;
    } decInfo_t;

    // Register view of one pipeline stage
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic               rdWrite;
        logic               isLoad;
    } regRec_t;

    // Memory view of one pipeline stage
    typedef struct packed {
        logic               valid;
        logic               memEnable;
        logic [`DATA_W-1:0] memAddr;
    } memRec_t;

    // Forwarding path selects for the issuing instruction
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;
        logic memToIdRs;
    } fwdSel_t;

endpackage

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazardUnit_defs.svh"

module instrDecode
    import hazardPkg::*;
(
    input  wire issueReq_t issue,
    output decInfo_t       dec
);

    logic [4:0]         opcode;
    logic [2:0]         opClass;
    logic               isStore;
    logic               jumpClass;
    logic [`DATA_W-1:0] effAddr;

    assign opcode  = issue.instr[`DATA_W-1 -: 5];
    assign opClass = opcode[4:2];
    assign isStore = (opcode == `OP_ST);

    // Only the jump class leaves a slot to squash
    always_comb begin
        case (opClass)
            `CLS_JUMP: jumpClass = 1'b1;
            default:   jumpClass = 1'b0;
        endcase
    end

    // Address generation wraps modulo 2^16
    assign effAddr = issue.baseData + issue.imm;

    always_comb begin
        dec.rs     = issue.instr[10:8];
        dec.rt     = issue.instr[7:5];
        dec.isNop  = (opcode == `OP_NOP);
        dec.isJr   = (opcode == `OP_JR);
        dec.isJump = jumpClass;
        dec.isLoad = (opcode == `OP_LD);

        // An explicit nop touches neither memory nor registers
        dec.memEnable = issue.memEnable & ~dec.isNop;
        dec.memAddr   = effAddr;
        dec.rd        = issue.rd;

        // Stores never write the register file
        dec.rdWrite = issue.rdWrite & ~isStore & ~dec.isNop;
    end

endmodule

`default_nettype wire

//--- stageTrack.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazardUnit_defs.svh"

module stageTrack #(
    parameter type recT = logic
) (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire recT  push,
    output recT       stages [`TRACK_DEPTH]
);

    // Index 0 is ID, the last index is WB
    localparam int Depth = `TRACK_DEPTH;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            // New record enters ID every cycle, bubble or not
            stages[0] <= push;
            for (int i = 1; i < Depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazardUnit_defs.svh"

module hazardDetect
    import hazardPkg::*;
(
    input  wire decInfo_t dec,
    input  wire regRec_t  regStages [`TRACK_DEPTH],
    input  wire memRec_t  memStages [`TRACK_DEPTH],
    output logic          regHaz,
    output logic          jrHaz,
    output logic          memHaz,
    output fwdSel_t       fwd
);

    localparam int StgId  = 0;
    localparam int StgEx  = 1;
    localparam int StgMem = 2;

    regRec_t idReg;
    regRec_t exReg;
    regRec_t memReg;
    logic    memMatch;

    // True when a stage holds a live writer of the given register
    function automatic logic writes(input regRec_t rec, input logic [`REG_AW-1:0] src);
        return rec.valid & rec.rdWrite & (rec.rd == src);
    endfunction

    assign idReg  = regStages[StgId];
    assign exReg  = regStages[StgEx];
    assign memReg = regStages[StgMem];

    // Load result is not ready until it leaves MEM
    assign regHaz = idReg.isLoad & (writes(idReg, dec.rs) | writes(idReg, dec.rt));

    // JR needs its target in ID, so EX results must wait a cycle
    assign jrHaz = dec.isJr &
                   (writes(idReg, dec.rs) | (writes(exReg, dec.rs) & exReg.isLoad));

    // Any in-flight access to the same address blocks this one
    always_comb begin
        memMatch = 1'b0;
        for (int i = 0; i < `TRACK_DEPTH; i++) begin
            if (memStages[i].valid && memStages[i].memEnable &&
                memStages[i].memAddr == dec.memAddr) begin
                memMatch = 1'b1;
            end
        end
        memHaz = dec.memEnable & memMatch;
    end

    // The youngest writer wins when two stages match
    always_comb begin
        fwd.exToExRs  = writes(idReg, dec.rs) & ~idReg.isLoad;
        fwd.memToExRs = writes(exReg, dec.rs) & ~fwd.exToExRs;
        fwd.exToExRt  = writes(idReg, dec.rt) & ~idReg.isLoad;
        fwd.memToExRt = writes(exReg, dec.rt) & ~fwd.exToExRt;

        // Paths into ID serve JR only
        fwd.exToIdRs  = dec.isJr & writes(exReg, dec.rs) & ~exReg.isLoad;
        fwd.memToIdRs = dec.isJr & writes(memReg, dec.rs) & ~fwd.exToIdRs;

        // Explicit nop reads nothing
        if (dec.isNop) begin
            fwd = '0;
        end
    end

endmodule

`default_nettype wire

//--- issueCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module issueCtrl
    import hazardPkg::*;
(
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     issueValid,
    input  wire decInfo_t dec,
    input  wire logic     regHaz,
    input  wire logic     jrHaz,
    input  wire logic     memHaz,
    output logic          pcStall,
    output logic          nop,
    output logic          squash,
    output regRec_t       pushReg,
    output memRec_t       pushMem
);

    logic anyHaz;
    logic issueFire;
    logic jumpFire;

    assign anyHaz = regHaz | jrHaz | memHaz;

    // Squash slot takes the instruction as a bubble, so no stall then
    assign pcStall = issueValid & anyHaz & ~dec.isNop & ~squash;

    // Bubble goes into ID in place of the presented instruction
    assign nop = issueValid & (pcStall | squash);

    // A real issue, records get tracked
    assign issueFire = issueValid & ~pcStall & ~squash;
    assign jumpFire  = issueFire & (dec.isJump | dec.isJr);

    // One-slot squash after a jump or JR
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            squash <= 1'b0;
        end else begin
            squash <= jumpFire;
        end
    end

    always_comb begin
        // An explicit nop travels as an invalid record
        pushReg.valid   = issueFire & ~dec.isNop;
        pushReg.rd      = dec.rd;
        pushReg.rdWrite = dec.rdWrite;
        pushReg.isLoad  = dec.isLoad;

        pushMem.valid     = issueFire & ~dec.isNop;
        pushMem.memEnable = dec.memEnable;
        pushMem.memAddr   = dec.memAddr;
    end

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazardUnit_defs.svh"

module hazardUnit
    import hazardPkg::*;
(
    input  wire logic      clk,
    input  wire logic      arstN,
    input  wire logic      issueValid,
    input  wire issueReq_t issue,
    output logic           pcStall,
    output logic           nop,
    output logic           squash,
    output fwdSel_t        fwd
);

    decInfo_t dec;
    regRec_t  pushReg;
    memRec_t  pushMem;
    regRec_t  regStages [`TRACK_DEPTH];
    memRec_t  memStages [`TRACK_DEPTH];
    logic     regHaz;
    logic     jrHaz;
    logic     memHaz;

    instrDecode decode_i (
        .issue (issue),
        .dec   (dec)
    );

    // Register destinations in flight
    stageTrack #(.recT(regRec_t)) regTrack_i (
        .clk    (clk),
        .arstN  (arstN),
        .push   (pushReg),
        .stages (regStages)
    );

    // Memory addresses in flight
    stageTrack #(.recT(memRec_t)) memTrack_i (
        .clk    (clk),
        .arstN  (arstN),
        .push   (pushMem),
        .stages (memStages)
    );

    hazardDetect detect_i (
        .dec       (dec),
        .regStages (regStages),
        .memStages (memStages),
        .regHaz    (regHaz),
        .jrHaz     (jrHaz),
        .memHaz    (memHaz),
        .fwd       (fwd)
    );

    issueCtrl issueCtrl_i (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .dec        (dec),
        .regHaz     (regHaz),
        .jrHaz      (jrHaz),
        .memHaz     (memHaz),
        .pcStall    (pcStall),
        .nop        (nop),
        .squash     (squash),
        .pushReg    (pushReg),
        .pushMem    (pushMem)
    );

endmodule

`default_nettype wire

//--- hazardUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit_assert
    import hazardPkg::*;
(
    input wire logic     clk,
    input wire logic     arstN,
    input wire logic     issueValid,
    input wire decInfo_t dec,
    input wire logic     pcStall,
    input wire logic     nop,
    input wire logic     squash
);

    logic jumpIssue;

    // A jump or JR that really enters ID
    assign jumpIssue = issueValid & ~pcStall & ~squash & (dec.isJump | dec.isJr);

    stallMeansNop: assert property (@(posedge clk) disable iff (!arstN) pcStall |-> nop)
        else $error("pcStall high without nop");

    nopNeedsValid: assert property (@(posedge clk) disable iff (!arstN) nop |-> issueValid)
        else $error("nop high without issueValid");

    // Slot after a jump is always squashed
    squashAfterJump: assert property (@(posedge clk) disable iff (!arstN) jumpIssue |=> squash)
        else $error("squash missing after a jump issued");

    stallNotInSquash: assert property (@(posedge clk) disable iff (!arstN) !(pcStall && squash))
        else $error("pcStall and squash high together");

endmodule

bind issueCtrl hazardUnit_assert issueCtrlAssert_i (
    .clk        (clk),
    .arstN      (arstN),
    .issueValid (issueValid),
    .dec        (dec),
    .pcStall    (pcStall),
    .nop        (nop),
    .squash     (squash)
);

`default_nettype wire

//--- hazardUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazardUnit_defs.svh"

module hazardUnit_tb
    import hazardPkg::*;
();

    // Plain ALU op and an unconditional jump outside the special opcodes
    localparam logic [4:0] OpAlu   = 5'b01000;
    localparam logic [4:0] OpJump  = 5'b00100;
    localparam int         MaxWait = 20;

    logic        clk;
    logic        arstN;
    logic        issueValid;
    issueReq_t   issue;
    logic        pcStall;
    logic        nop;
    logic        squash;
    fwdSel_t     fwd;
    logic [31:0] lfsrState;

    hazardUnit hazardUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .issue      (issue),
        .pcStall    (pcStall),
        .nop        (nop),
        .squash     (squash),
        .fwd        (fwd)
    );

    always #50 clk = ~clk;

    task automatic stopRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            stopRun();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    function automatic issueReq_t makeReq(
        input logic [4:0]         op,
        input logic [`REG_AW-1:0] rs,
        input logic [`REG_AW-1:0] rt,
        input logic [`REG_AW-1:0] rd,
        input logic               rdWrite,
        input logic [`DATA_W-1:0] base,
        input logic [`DATA_W-1:0] imm
    );
        issueReq_t r;
        r.instr     = {op, rs, rt, 5'b00000};
        r.rd        = rd;
        r.rdWrite   = rdWrite;
        r.memEnable = (op == `OP_LD) || (op == `OP_ST);
        r.baseData  = base;
        r.imm       = imm;
        return r;
    endfunction

    task automatic idle(input int n);
        issueValid = 1'b0;
        repeat (n) begin
            @(negedge clk);
            checkEq(32'(pcStall), 0, "pcStall while idle");
            checkEq(32'(nop), 0, "nop while idle");
            @(posedge clk);
            #5;
        end
    endtask

    // Holds the instruction until it is consumed and samples mid-cycle
    task automatic present(input issueReq_t req, output int stalls, output int nops,
                           output logic sq, output fwdSel_t f);
        int   waited;
        logic done;
        issue      = req;
        issueValid = 1'b1;
        stalls     = 0;
        nops       = 0;
        waited     = 0;
        done       = 1'b0;
        sq         = 1'b0;
        f          = '0;
        while (!done) begin
            @(negedge clk);
            if (nop) begin
                nops++;
            end
            if (pcStall) begin
                stalls++;
            end else begin
                sq   = squash;
                f    = fwd;
                done = 1'b1;
            end
            waited++;
            if (!done && waited >= MaxWait) begin
                $display("Timeout: instruction still stalled after %0d cycles", waited);
                stopRun();
            end
            @(posedge clk);
            #5;
        end
        issueValid = 1'b0;
    endtask

    task automatic issueAndCheck(input issueReq_t req, input int expStalls, input logic expSq,
                                 input fwdSel_t expFwd, input string what);
        int      stalls;
        int      nops;
        logic    sq;
        fwdSel_t f;
        present(req, stalls, nops, sq, f);
        checkEq(stalls, expStalls, {what, ": stall cycles"});
        // Every stalled or squashed cycle puts a bubble into ID
        checkEq(nops, expStalls + int'(expSq), {what, ": bubble cycles"});
        checkEq(32'(sq), 32'(expSq), {what, ": squash"});
        checkEq(32'(f), 32'(expFwd), {what, ": forward selects"});
    endtask

    task automatic testIndependent();
        logic [15:0]        r;
        logic [`REG_AW-1:0] x;
        checkEq(32'(pcStall), 0, "pcStall after reset");
        checkEq(32'(nop), 0, "nop after reset");
        checkEq(32'(squash), 0, "squash after reset");
        checkEq(32'(fwd), 0, "forward selects after reset");
        randomBits(`REG_AW, r);
        x = r[`REG_AW-1:0];
        issueAndCheck(makeReq(OpAlu, x + 3'd1, x + 3'd2, x, 1'b1, '0, '0), 0, 1'b0, '0,
                      "first ALU");
        idle(2);
        issueAndCheck(makeReq(OpAlu, x + 3'd4, x + 3'd5, x + 3'd3, 1'b1, '0, '0), 0, 1'b0, '0,
                      "second ALU");
        idle(5);
    endtask

    task automatic testAluForward();
        logic [15:0]        r;
        logic [`REG_AW-1:0] x;
        issueReq_t          writer;
        issueReq_t          rsReader;
        issueReq_t          rtReader;
        fwdSel_t            e;
        randomBits(`REG_AW, r);
        x        = r[`REG_AW-1:0];
        writer   = makeReq(OpAlu, x + 3'd1, x + 3'd2, x, 1'b1, '0, '0);
        rsReader = makeReq(OpAlu, x, x + 3'd3, x + 3'd4, 1'b0, '0, '0);
        rtReader = makeReq(OpAlu, x + 3'd3, x, x + 3'd4, 1'b0, '0, '0);
        // Writer still in ID feeds EX directly
        e = '0;
        e.exToExRs = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        issueAndCheck(rsReader, 0, 1'b0, e, "rs reader back to back");
        idle(5);
        e = '0;
        e.memToExRs = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        idle(1);
        issueAndCheck(rsReader, 0, 1'b0, e, "rs reader after gap");
        idle(5);
        e = '0;
        e.exToExRt = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        issueAndCheck(rtReader, 0, 1'b0, e, "rt reader back to back");
        idle(5);
        e = '0;
        e.memToExRt = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        idle(1);
        issueAndCheck(rtReader, 0, 1'b0, e, "rt reader after gap");
        idle(5);
    endtask

    task automatic testLoadUse();
        logic [15:0]        r;
        logic [15:0]        base;
        logic [`REG_AW-1:0] x;
        fwdSel_t            e;
        randomBits(`REG_AW, r);
        randomBits(`DATA_W, base);
        x = r[`REG_AW-1:0];
        e = '0;
        e.memToExRs = 1'b1;
        issueAndCheck(makeReq(`OP_LD, x + 3'd1, x + 3'd2, x, 1'b1, base, 16'h0004), 0, 1'b0, '0,
                      "load");
        issueAndCheck(makeReq(OpAlu, x, x + 3'd3, x + 3'd4, 1'b0, '0, '0), 1, 1'b0, e,
                      "reader after load");
        idle(5);
    endtask

    task automatic testMemConflict();
        logic [15:0]        r;
        logic [15:0]        base;
        logic [15:0]        imm;
        logic [15:0]        addr;
        logic [15:0]        otherBase;
        logic [`REG_AW-1:0] x;
        issueReq_t          st;
        issueReq_t          req;
        randomBits(`REG_AW, r);
        randomBits(`DATA_W, base);
        randomBits(`DATA_W, imm);
        x         = r[`REG_AW-1:0];
        addr      = base + imm;
        otherBase = base ^ 16'h0100;
        st        = makeReq(`OP_ST, x, x + 3'd1, x + 3'd2, 1'b0, base, imm);
        // Same sum from a different base waits until the store leaves WB
        issueAndCheck(st, 0, 1'b0, '0, "store");
        req = makeReq(`OP_LD, x + 3'd3, x + 3'd4, x + 3'd5, 1'b1, otherBase, addr - otherBase);
        issueAndCheck(req, 4, 1'b0, '0, "load from stored address");
        idle(5);
        issueAndCheck(st, 0, 1'b0, '0, "store");
        req.imm = addr - otherBase + 16'd1;
        issueAndCheck(req, 0, 1'b0, '0, "load from other address");
        idle(5);
        issueAndCheck(st, 0, 1'b0, '0, "store");
        req           = makeReq(`OP_NOP, x, x + 3'd1, x, 1'b0, base, imm);
        req.memEnable = 1'b1;
        issueAndCheck(req, 0, 1'b0, '0, "explicit nop");
        idle(5);
    endtask

    task automatic testJumpSquash();
        logic [15:0]        r;
        logic [`REG_AW-1:0] x;
        randomBits(`REG_AW, r);
        x = r[`REG_AW-1:0];
        issueAndCheck(makeReq(OpJump, x + 3'd1, x + 3'd2, x, 1'b0, '0, '0), 0, 1'b0, '0, "jump");
        issueAndCheck(makeReq(OpAlu, x + 3'd1, x + 3'd2, x, 1'b1, '0, '0), 0, 1'b1, '0,
                      "slot after jump");
        // The squashed writer never entered ID
        issueAndCheck(makeReq(OpAlu, x, x + 3'd3, x + 3'd4, 1'b0, '0, '0), 0, 1'b0, '0,
                      "reader after squashed writer");
        idle(5);
    endtask

    task automatic testJumpRegister();
        logic [15:0]        r;
        logic [`REG_AW-1:0] x;
        issueReq_t          writer;
        issueReq_t          jr;
        fwdSel_t            e;
        randomBits(`REG_AW, r);
        x      = r[`REG_AW-1:0];
        writer = makeReq(OpAlu, x + 3'd1, x + 3'd2, x, 1'b1, '0, '0);
        jr     = makeReq(`OP_JR, x, x + 3'd3, x + 3'd4, 1'b0, '0, '0);
        // Writer in EX also matches the EX-input path for rs
        e = '0;
        e.exToIdRs  = 1'b1;
        e.memToExRs = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        issueAndCheck(jr, 1, 1'b0, e, "JR right after writer");
        idle(5);
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        idle(1);
        issueAndCheck(jr, 0, 1'b0, e, "JR one idle cycle after writer");
        idle(5);
        e = '0;
        e.memToIdRs = 1'b1;
        issueAndCheck(writer, 0, 1'b0, '0, "writer");
        idle(2);
        issueAndCheck(jr, 0, 1'b0, e, "JR two idle cycles after writer");
        idle(5);
        issueAndCheck(makeReq(`OP_LD, x + 3'd1, x + 3'd2, x, 1'b1, 16'h0040, '0), 0, 1'b0, '0,
                      "load");
        issueAndCheck(jr, 2, 1'b0, e, "JR after load");
        idle(5);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        lfsrState  = 32'hb610_4810;
        repeat (16) @(posedge clk);
        #5;
        arstN = 1'b1;
        testIndependent();
        testAluForward();
        testLoadUse();
        testMemConflict();
        testJumpSquash();
        testJumpRegister();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- hazardUnit.f
+incdir+.
hazardPkg.sv
instrDecode.sv
stageTrack.sv
hazardDetect.sv
issueCtrl.sv
hazardUnit.sv
hazardUnit_assert.sv
hazardUnit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module hazardUnit_tb \
    -f hazardUnit.f \
    -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
